//--- cpu.f
+incdir+design
design/rv32i_pkg.sv
design/cpu_ctrl_pkg.sv
design/dmem_if.sv
design/control.sv
design/regfile.sv
design/datapath.sv
design/mem_align.sv
design/cpu.sv
tests/cpu_props.sv
tests/cpu_tb.sv

//--- design/control.sv
module control (
    input  rv32i_pkg::word_t          instr,
    output cpu_ctrl_pkg::ctrl_word_t  ctrl
);

    rv32i_pkg::opcode_t opcode;
    logic [2:0]         funct3;
    logic               funct7_b5;

    assign opcode    = rv32i_pkg::opcode_t'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];

    always_comb begin
        // defaults describe a no-op, used for unknown opcodes too
        ctrl.alu_a_sel = cpu_ctrl_pkg::alu_a_rs1;
        ctrl.alu_b_sel = cpu_ctrl_pkg::alu_b_rs2;
        ctrl.imm_sel   = cpu_ctrl_pkg::imm_i;
        ctrl.wb_sel    = cpu_ctrl_pkg::wb_alu;
        ctrl.pc_sel    = cpu_ctrl_pkg::pc_next;
        ctrl.alu_op    = rv32i_pkg::alu_add;
        ctrl.cmp_op    = rv32i_pkg::branch_f3_t'(funct3);
        ctrl.ldst_f3   = rv32i_pkg::ldst_f3_t'(funct3);
        ctrl.mem_read  = 1'b0;
        ctrl.mem_write = 1'b0;
        ctrl.rd_we     = 1'b0;
        ctrl.is_branch = 1'b0;

        case (opcode)
            rv32i_pkg::op_lui: begin
                ctrl.imm_sel = cpu_ctrl_pkg::imm_u;
                ctrl.wb_sel  = cpu_ctrl_pkg::wb_uimm;
                ctrl.rd_we   = 1'b1;
            end
            rv32i_pkg::op_auipc: begin
                ctrl.alu_a_sel = cpu_ctrl_pkg::alu_a_pc;
                ctrl.alu_b_sel = cpu_ctrl_pkg::alu_b_imm;
                ctrl.imm_sel   = cpu_ctrl_pkg::imm_u;
                ctrl.rd_we     = 1'b1;
            end
            rv32i_pkg::op_jal: begin
                // target from the pc+imm adder, link is pc+4
                ctrl.imm_sel = cpu_ctrl_pkg::imm_j;
                ctrl.pc_sel  = cpu_ctrl_pkg::pc_branch;
                ctrl.wb_sel  = cpu_ctrl_pkg::wb_pc4;
                ctrl.rd_we   = 1'b1;
            end
            rv32i_pkg::op_jalr: begin
                ctrl.alu_b_sel = cpu_ctrl_pkg::alu_b_imm;
                ctrl.pc_sel    = cpu_ctrl_pkg::pc_jalr;
                ctrl.wb_sel    = cpu_ctrl_pkg::wb_pc4;
                ctrl.rd_we     = 1'b1;
            end
            rv32i_pkg::op_br: begin
                // comparator sees rs1 against rs2
                ctrl.imm_sel   = cpu_ctrl_pkg::imm_b;
                ctrl.pc_sel    = cpu_ctrl_pkg::pc_branch;
                ctrl.is_branch = 1'b1;
            end
            rv32i_pkg::op_load: begin
                ctrl.alu_b_sel = cpu_ctrl_pkg::alu_b_imm;
                ctrl.wb_sel    = cpu_ctrl_pkg::wb_load;
                ctrl.mem_read  = 1'b1;
                ctrl.rd_we     = 1'b1;
            end
            rv32i_pkg::op_store: begin
                ctrl.alu_b_sel = cpu_ctrl_pkg::alu_b_imm;
                ctrl.imm_sel   = cpu_ctrl_pkg::imm_s;
                ctrl.mem_write = 1'b1;
            end
            rv32i_pkg::op_imm: begin
                ctrl.alu_b_sel = cpu_ctrl_pkg::alu_b_imm;
                ctrl.rd_we     = 1'b1;
                // funct7 bit only meaningful for the right shift
                ctrl.alu_op = rv32i_pkg::alu_op_t'({funct3 == 3'b101 && funct7_b5, funct3});
            end
            rv32i_pkg::op_reg: begin
                ctrl.rd_we  = 1'b1;
                ctrl.alu_op = rv32i_pkg::alu_op_t'({funct7_b5, funct3});
            end
            default: begin
            end
        endcase

        // slt/sltu go through the comparator
        if ((opcode == rv32i_pkg::op_imm || opcode == rv32i_pkg::op_reg) &&
            funct3[2:1] == 2'b01) begin
            ctrl.wb_sel = cpu_ctrl_pkg::wb_cmp;
            ctrl.cmp_op = funct3[0] ? rv32i_pkg::br_bltu : rv32i_pkg::br_blt;
        end
    end

endmodule : control

//--- design/cpu.sv
module cpu (
    input  logic                clk,
    input  logic                rst_n,

    // instruction cache, aligned
    output rv32i_pkg::word_t    i_addr,
    input  rv32i_pkg::word_t    i_rdata,
    output logic                i_read,
    input  logic                i_resp,

    // data cache, aligned
    output rv32i_pkg::word_t    d_addr,
    input  rv32i_pkg::word_t    d_rdata,
    output rv32i_pkg::word_t    d_wdata,
    output logic [3:0]          d_byte_enable,
    output logic                d_read,
    output logic                d_write,
    input  logic                d_resp,

    // one pulse per finished instruction
    output logic                retire_valid,
    output rv32i_pkg::word_t    retire_pc,
    output rv32i_pkg::reg_idx_t retire_rd,
    output rv32i_pkg::word_t    retire_wdata
);

    // decode loop between datapath and control
    rv32i_pkg::word_t         instr;
    cpu_ctrl_pkg::ctrl_word_t ctrl;

    // unaligned channel, datapath to aligner
    dmem_if dmem ();

    control control (
        .instr (instr),
        .ctrl  (ctrl)
    );

    datapath datapath (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_addr       (i_addr),
        .i_rdata      (i_rdata),
        .i_read       (i_read),
        .i_resp       (i_resp),
        .instr        (instr),
        .ctrl         (ctrl),
        .dmem         (dmem.core),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_wdata (retire_wdata)
    );

    mem_align d_align (
        .dmem          (dmem.align),
        .d_addr        (d_addr),
        .d_wdata       (d_wdata),
        .d_byte_enable (d_byte_enable),
        .d_read        (d_read),
        .d_write       (d_write),
        .d_rdata       (d_rdata),
        .d_resp        (d_resp)
    );

endmodule : cpu

//--- design/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    // first alu operand
    typedef enum logic {
        alu_a_rs1,
        alu_a_pc
    } alu_a_sel_t;

    // second alu operand, also feeds the comparator
    typedef enum logic {
        alu_b_rs2,
        alu_b_imm
    } alu_b_sel_t;

    // immediate formats
    typedef enum logic [2:0] {
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j
    } imm_sel_t;

    // register writeback source
    typedef enum logic [2:0] {
        wb_alu,
        wb_cmp,
        wb_load,
        wb_pc4,
        wb_uimm
    } wb_sel_t;

    // next pc source
    typedef enum logic [1:0] {
        pc_next,
        pc_branch,
        pc_jalr
    } pc_sel_t;

    // multi-cycle sequencer, one instruction in flight
    typedef enum logic [1:0] {
        st_fetch,
        st_execute,
        st_memory,
        st_writeback
    } seq_state_t;

    typedef struct packed {
        alu_a_sel_t            alu_a_sel;
        alu_b_sel_t            alu_b_sel;
        imm_sel_t              imm_sel;
        wb_sel_t               wb_sel;
        pc_sel_t               pc_sel;
        rv32i_pkg::alu_op_t    alu_op;
        rv32i_pkg::branch_f3_t cmp_op;
        rv32i_pkg::ldst_f3_t   ldst_f3;
        logic                  mem_read;
        logic                  mem_write;
        logic                  rd_we;
        // conditional redirect, taken only when the compare holds
        logic                  is_branch;
    } ctrl_word_t;

endpackage : cpu_ctrl_pkg

//--- design/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// first fetch address out of reset
`define CPU_RESET_PC 32'h0000_0000

// integer register count, x0 included
`define CPU_NUM_REGS 32

`endif

//--- design/datapath.sv
`include "cpu_settings.svh"

module datapath (
    input  logic                      clk,
    input  logic                      rst_n,
    // instruction cache
    output rv32i_pkg::word_t          i_addr,
    input  rv32i_pkg::word_t          i_rdata,
    output logic                      i_read,
    input  logic                      i_resp,
    // decode loop
    output rv32i_pkg::word_t          instr,
    input  cpu_ctrl_pkg::ctrl_word_t  ctrl,
    // unaligned data channel
    dmem_if.core                      dmem,
    // retire report
    output logic                      retire_valid,
    output rv32i_pkg::word_t          retire_pc,
    output rv32i_pkg::reg_idx_t       retire_rd,
    output rv32i_pkg::word_t          retire_wdata
);

    cpu_ctrl_pkg::seq_state_t state;
    rv32i_pkg::word_t         pc;
    rv32i_pkg::word_t         pc_plus4;
    rv32i_pkg::word_t         br_target;
    rv32i_pkg::word_t         next_pc;
    rv32i_pkg::word_t         imm;
    rv32i_pkg::word_t         rs1_data;
    rv32i_pkg::word_t         rs2_data;
    rv32i_pkg::word_t         alu_a;
    rv32i_pkg::word_t         alu_b;
    rv32i_pkg::word_t         alu_out;
    rv32i_pkg::word_t         alu_q;
    rv32i_pkg::word_t         load_q;
    rv32i_pkg::word_t         wb_data;
    rv32i_pkg::reg_idx_t      rd;
    logic                     cmp_out;
    logic                     cmp_q;
    logic                     d_read_q;
    logic                     d_write_q;
    logic                     rd_we;

    assign rd     = instr[11:7];
    assign rd_we  = ctrl.rd_we && state == cpu_ctrl_pkg::st_writeback;
    assign i_addr = pc;

    regfile regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .we       (rd_we),
        .rd       (rd),
        .wdata    (wb_data),
        .rs1      (instr[19:15]),
        .rs2      (instr[24:20]),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // immediate formats
    always_comb begin
        case (ctrl.imm_sel)
            cpu_ctrl_pkg::imm_i: imm = {{20{instr[31]}}, instr[31:20]};
            cpu_ctrl_pkg::imm_s: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            cpu_ctrl_pkg::imm_b: imm = {{19{instr[31]}}, instr[31], instr[7],
                                        instr[30:25], instr[11:8], 1'b0};
            cpu_ctrl_pkg::imm_u: imm = {instr[31:12], 12'b0};
            default:             imm = {{11{instr[31]}}, instr[31], instr[19:12],
                                        instr[20], instr[30:21], 1'b0};
        endcase
    end

    assign alu_a = (ctrl.alu_a_sel == cpu_ctrl_pkg::alu_a_pc) ? pc : rs1_data;
    assign alu_b = (ctrl.alu_b_sel == cpu_ctrl_pkg::alu_b_imm) ? imm : rs2_data;

    // slt/sltu results come from the comparator, not from here
    always_comb begin
        case (ctrl.alu_op)
            rv32i_pkg::alu_sub:  alu_out = alu_a - alu_b;
            rv32i_pkg::alu_sll:  alu_out = alu_a << alu_b[4:0];
            rv32i_pkg::alu_xor:  alu_out = alu_a ^ alu_b;
            rv32i_pkg::alu_srl:  alu_out = alu_a >> alu_b[4:0];
            rv32i_pkg::alu_sra:  alu_out = $signed(alu_a) >>> alu_b[4:0];
            rv32i_pkg::alu_or:   alu_out = alu_a | alu_b;
            rv32i_pkg::alu_and:  alu_out = alu_a & alu_b;
            default:             alu_out = alu_a + alu_b;
        endcase
    end

    // rs1 against the second operand, rs2 for branches
    always_comb begin
        case (ctrl.cmp_op)
            rv32i_pkg::br_beq:  cmp_out = rs1_data == alu_b;
            rv32i_pkg::br_bne:  cmp_out = rs1_data != alu_b;
            rv32i_pkg::br_blt:  cmp_out = $signed(rs1_data) < $signed(alu_b);
            rv32i_pkg::br_bge:  cmp_out = $signed(rs1_data) >= $signed(alu_b);
            rv32i_pkg::br_bltu: cmp_out = rs1_data < alu_b;
            default:            cmp_out = rs1_data >= alu_b;
        endcase
    end

    assign pc_plus4  = pc + 32'd4;
    assign br_target = pc + imm;

    always_comb begin
        case (ctrl.pc_sel)
            // jal always redirects, branches only on a true compare
            cpu_ctrl_pkg::pc_branch: next_pc = (!ctrl.is_branch || cmp_q) ? br_target : pc_plus4;
            cpu_ctrl_pkg::pc_jalr:   next_pc = {alu_q[31:1], 1'b0};
            default:                 next_pc = pc_plus4;
        endcase
    end

    always_comb begin
        case (ctrl.wb_sel)
            cpu_ctrl_pkg::wb_cmp:  wb_data = {31'b0, cmp_q};
            cpu_ctrl_pkg::wb_load: wb_data = load_q;
            cpu_ctrl_pkg::wb_pc4:  wb_data = pc_plus4;
            cpu_ctrl_pkg::wb_uimm: wb_data = imm;
            default:               wb_data = alu_q;
        endcase
    end

    // data request, address from the latched alu result
    assign dmem.addr    = alu_q;
    assign dmem.wdata   = rs2_data;
    assign dmem.ldst_f3 = ctrl.ldst_f3;
    assign dmem.read    = d_read_q;
    assign dmem.write   = d_write_q;

    // sequencer and request lines
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= cpu_ctrl_pkg::st_fetch;
            pc           <= `CPU_RESET_PC;
            i_read       <= 1'b0;
            d_read_q     <= 1'b0;
            d_write_q    <= 1'b0;
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= 1'b0;
            case (state)
                cpu_ctrl_pkg::st_fetch: begin
                    // first fetch after reset raises the request here
                    if (i_read && i_resp) begin
                        i_read <= 1'b0;
                        state  <= cpu_ctrl_pkg::st_execute;
                    end else begin
                        i_read <= 1'b1;
                    end
                end
                cpu_ctrl_pkg::st_execute: begin
                    d_read_q  <= ctrl.mem_read;
                    d_write_q <= ctrl.mem_write;
                    state     <= (ctrl.mem_read || ctrl.mem_write) ? cpu_ctrl_pkg::st_memory
                                                                    : cpu_ctrl_pkg::st_writeback;
                end
                cpu_ctrl_pkg::st_memory: begin
                    if (dmem.resp) begin
                        d_read_q  <= 1'b0;
                        d_write_q <= 1'b0;
                        state     <= cpu_ctrl_pkg::st_writeback;
                    end
                end
                default: begin
                    pc           <= next_pc;
                    retire_valid <= 1'b1;
                    // next fetch request goes out with the new pc
                    i_read       <= 1'b1;
                    state        <= cpu_ctrl_pkg::st_fetch;
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (state == cpu_ctrl_pkg::st_fetch && i_read && i_resp) begin
            instr <= i_rdata;
        end
        if (state == cpu_ctrl_pkg::st_execute) begin
            alu_q <= alu_out;
            cmp_q <= cmp_out;
        end
        if (state == cpu_ctrl_pkg::st_memory && dmem.resp) begin
            load_q <= dmem.rdata;
        end
        if (state == cpu_ctrl_pkg::st_writeback) begin
            retire_pc    <= pc;
            // rd and value read zero when nothing lands in the file
            retire_rd    <= ctrl.rd_we ? rd : '0;
            retire_wdata <= (ctrl.rd_we && rd != '0) ? wb_data : '0;
        end
    end

endmodule : datapath

//--- design/dmem_if.sv
interface dmem_if;

    // unaligned request from the core
    rv32i_pkg::word_t    addr;
    rv32i_pkg::word_t    wdata;
    rv32i_pkg::ldst_f3_t ldst_f3;
    logic                read;
    logic                write;

    // aligned and extended load result
    rv32i_pkg::word_t    rdata;
    // cache response, forwarded by the aligner
    logic                resp;

    modport core (
        output addr, wdata, ldst_f3, read, write,
        input  rdata, resp
    );

    modport align (
        input  addr, wdata, ldst_f3, read, write,
        output rdata, resp
    );

endinterface : dmem_if

//--- design/mem_align.sv
module mem_align (
    dmem_if.align            dmem,
    // aligned data cache side
    output rv32i_pkg::word_t d_addr,
    output rv32i_pkg::word_t d_wdata,
    output logic [3:0]       d_byte_enable,
    output logic             d_read,
    output logic             d_write,
    input  rv32i_pkg::word_t d_rdata,
    input  logic             d_resp
);

    logic [1:0]       offset;
    logic [4:0]       lane_shift;
    rv32i_pkg::word_t lane;

    assign offset     = dmem.addr[1:0];
    assign lane_shift = {offset, 3'b000};

    // cache only sees word addresses
    assign d_addr    = {dmem.addr[31:2], 2'b00};
    assign d_read    = dmem.read;
    assign d_write   = dmem.write;
    assign dmem.resp = d_resp;

    // store data moved up into its lane
    assign d_wdata = dmem.wdata << lane_shift;

    // addressed lane moved down to bit 0
    assign lane = d_rdata >> lane_shift;

    always_comb begin
        case (dmem.ldst_f3)
            rv32i_pkg::ldst_b: begin
                d_byte_enable = 4'b0001 << offset;
                dmem.rdata    = {{24{lane[7]}}, lane[7:0]};
            end
            rv32i_pkg::ldst_bu: begin
                d_byte_enable = 4'b0001 << offset;
                dmem.rdata    = {24'b0, lane[7:0]};
            end
            rv32i_pkg::ldst_h: begin
                d_byte_enable = 4'b0011 << offset;
                dmem.rdata    = {{16{lane[15]}}, lane[15:0]};
            end
            rv32i_pkg::ldst_hu: begin
                d_byte_enable = 4'b0011 << offset;
                dmem.rdata    = {16'b0, lane[15:0]};
            end
            default: begin
                // word access, full mask and no shift
                d_byte_enable = 4'b1111;
                dmem.rdata    = d_rdata;
            end
        endcase
    end

endmodule : mem_align

//--- design/regfile.sv
`include "cpu_settings.svh"

module regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                we,
    input  rv32i_pkg::reg_idx_t rd,
    input  rv32i_pkg::word_t    wdata,
    input  rv32i_pkg::reg_idx_t rs1,
    input  rv32i_pkg::reg_idx_t rs2,
    output rv32i_pkg::word_t    rs1_data,
    output rv32i_pkg::word_t    rs2_data
);

    rv32i_pkg::word_t regs [`CPU_NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            // x0 never written, so it reads zero
            regs[rd] <= wdata;
        end
    end

    // asynchronous read ports
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule : regfile

//--- design/rv32i_pkg.sv
package rv32i_pkg;

    // data and address word
    typedef logic [31:0] word_t;

    // architectural register index
    typedef logic [4:0] reg_idx_t;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    // encoded as {funct7[5], funct3} so decode is a direct cast
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_t;

    // branch funct3, also reused for slt/sltu compares
    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } branch_f3_t;

    // load/store width, funct3
    typedef enum logic [2:0] {
        ldst_b  = 3'b000,
        ldst_h  = 3'b001,
        ldst_w  = 3'b010,
        ldst_bu = 3'b100,
        ldst_hu = 3'b101
    } ldst_f3_t;

endpackage : rv32i_pkg

//--- run.sh
#!/bin/sh
# build and run with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f cpu.f --top-module cpu_tb -o cpu_sim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/cpu_sim > sim.log 2>&1
cat sim.log
grep -q "test failed" sim.log && exit 1 || grep -q "test passed" sim.log || exit 1
exit 0

//--- tests/cpu_props.sv
module cpu_props (
    input logic             clk,
    input logic             rst_n,
    input rv32i_pkg::word_t i_addr,
    input logic             i_read,
    input logic             i_resp,
    input rv32i_pkg::word_t d_addr,
    input logic             d_read,
    input logic             d_write,
    input logic             d_resp
);

    // fetch request holds with a stable address until answered
    ifetch_hold: assert property (@(posedge clk) disable iff (!rst_n)
        i_read && !i_resp |=> i_read && $stable(i_addr))
        else $error("i_read dropped or i_addr moved before i_resp");

    // one data access at a time
    data_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        !(d_read && d_write))
        else $error("d_read and d_write high together");

    // pending data request keeps its address
    data_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (d_read || d_write) && !d_resp |=> (d_read || d_write) && $stable(d_addr))
        else $error("data request dropped or d_addr moved before d_resp");

endmodule : cpu_props

bind cpu cpu_props props (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_addr  (i_addr),
    .i_read  (i_read),
    .i_resp  (i_resp),
    .d_addr  (d_addr),
    .d_read  (d_read),
    .d_write (d_write),
    .d_resp  (d_resp)
);

//--- tests/cpu_tb.sv
`include "cpu_settings.svh"

module cpu_tb;

    logic clk = 1'b0;
    logic rst_n;
    rv32i_pkg::word_t    i_addr, i_rdata, d_addr, d_rdata, d_wdata;
    rv32i_pkg::word_t    retire_pc, retire_wdata;
    rv32i_pkg::reg_idx_t retire_rd;
    logic [3:0]          d_byte_enable;
    logic                i_read, i_resp, d_read, d_write, d_resp, retire_valid;

    // program memory and expected retire rows, in retire order
    rv32i_pkg::word_t    imem [128];
    int                  n_imem;
    rv32i_pkg::word_t    exp_pc [$];
    rv32i_pkg::word_t    exp_val [$];
    rv32i_pkg::reg_idx_t exp_rd [$];
    // expected store lanes, oldest first
    logic [3:0]          st_be [$];
    rv32i_pkg::word_t    st_wd [$];
    rv32i_pkg::word_t    dmem [64];
    int                  cycles;
    bit                  i_busy, d_busy;
    int                  i_cnt, d_cnt;

    cpu dut (.*);

    always #4 clk = ~clk;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    // instruction encoders
    function automatic rv32i_pkg::word_t enc_i(input logic [6:0] op, input logic [2:0] f3,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [31:0] imm);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic rv32i_pkg::word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic rv32i_pkg::word_t enc_s(input logic [2:0] f3, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [31:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic rv32i_pkg::word_t enc_b(input logic [2:0] f3, input logic [4:0] rs1,
            input logic [4:0] rs2, input logic [31:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic rv32i_pkg::word_t enc_j(input logic [4:0] rd, input logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // one instruction that retires with rd and value
    task automatic put(input rv32i_pkg::word_t ins, input logic [4:0] rd,
            input rv32i_pkg::word_t val);
        exp_pc.push_back(`CPU_RESET_PC + 32'(n_imem * 4));
        exp_rd.push_back(rd);
        exp_val.push_back(val);
        imem[n_imem] = ins;
        n_imem++;
    endtask

    // jumped over, never retires
    task automatic skip(input rv32i_pkg::word_t ins);
        imem[n_imem] = ins;
        n_imem++;
    endtask

    task automatic put_store(input rv32i_pkg::word_t ins, input logic [3:0] be,
            input rv32i_pkg::word_t wd);
        put(ins, 5'd0, 32'h0);
        st_be.push_back(be);
        st_wd.push_back(wd);
    endtask

    task automatic build_program();
        rv32i_pkg::word_t poison;
        poison = enc_i(rv32i_pkg::op_imm, 3'b000, 5'd31, 5'd0, 32'd1);
        // alu, lui, auipc
        put(enc_i(rv32i_pkg::op_imm, 3'b000, 1, 0, 16), 1, 32'h10);
        put(enc_i(rv32i_pkg::op_imm, 3'b000, 2, 0, -8), 2, 32'hffff_fff8);
        put(enc_i(rv32i_pkg::op_imm, 3'b000, 3, 0, 3), 3, 32'h3);
        put(enc_r(7'h20, 3'b101, 4, 2, 3), 4, 32'hffff_ffff);
        put(enc_r(7'h00, 3'b101, 5, 2, 3), 5, 32'h1fff_ffff);
        put(enc_i(rv32i_pkg::op_imm, 3'b101, 6, 2, 32'h401), 6, 32'hffff_fffc);
        put(enc_r(7'h00, 3'b010, 7, 2, 3), 7, 32'h1);
        put(enc_r(7'h00, 3'b011, 8, 2, 3), 8, 32'h0);
        put(enc_i(rv32i_pkg::op_imm, 3'b010, 9, 2, -7), 9, 32'h1);
        put(enc_i(rv32i_pkg::op_imm, 3'b011, 10, 3, -1), 10, 32'h1);
        put(enc_r(7'h20, 3'b000, 11, 3, 2), 11, 32'hb);
        put(enc_i(rv32i_pkg::op_imm, 3'b100, 12, 2, 32'hff), 12, 32'hffff_ff07);
        put(enc_r(7'h00, 3'b110, 13, 3, 1), 13, 32'h13);
        put(enc_r(7'h00, 3'b111, 14, 2, 1), 14, 32'h10);
        put(enc_i(rv32i_pkg::op_imm, 3'b001, 15, 3, 30), 15, 32'hc000_0000);
        put(enc_r(7'h00, 3'b001, 16, 3, 3), 16, 32'h18);
        put(enc_r(7'h00, 3'b100, 17, 1, 3), 17, 32'h13);
        put(enc_i(rv32i_pkg::op_imm, 3'b110, 18, 0, -1), 18, 32'hffff_ffff);
        put(enc_i(rv32i_pkg::op_imm, 3'b111, 19, 2, 32'h7c), 19, 32'h78);
        put(enc_r(7'h00, 3'b000, 20, 1, 2), 20, 32'h8);
        put({20'h12345, 5'd21, 7'b0110111}, 21, 32'h1234_5000);
        put({20'h00001, 5'd22, 7'b0010111}, 22, 32'h0000_1054);
        // x0 ignores the write and reads back zero
        put(enc_i(rv32i_pkg::op_imm, 3'b000, 0, 1, 5), 0, 32'h0);
        put(enc_r(7'h00, 3'b000, 23, 0, 3), 23, 32'h3);
        // loads from word 0x10 = 80f17f82
        put(enc_i(rv32i_pkg::op_load, 3'b000, 24, 1, 0), 24, 32'hffff_ff82);
        put(enc_i(rv32i_pkg::op_load, 3'b000, 25, 1, 1), 25, 32'h0000_007f);
        put(enc_i(rv32i_pkg::op_load, 3'b000, 26, 1, 2), 26, 32'hffff_fff1);
        put(enc_i(rv32i_pkg::op_load, 3'b100, 27, 1, 3), 27, 32'h0000_0080);
        put(enc_i(rv32i_pkg::op_load, 3'b100, 28, 1, 0), 28, 32'h0000_0082);
        put(enc_i(rv32i_pkg::op_load, 3'b001, 29, 1, 0), 29, 32'h0000_7f82);
        put(enc_i(rv32i_pkg::op_load, 3'b001, 30, 1, 2), 30, 32'hffff_80f1);
        put(enc_i(rv32i_pkg::op_load, 3'b101, 31, 1, 2), 31, 32'h0000_80f1);
        put(enc_i(rv32i_pkg::op_load, 3'b010, 24, 1, 0), 24, 32'h80f1_7f82);
        put(enc_i(rv32i_pkg::op_load, 3'b000, 25, 1, 3), 25, 32'hffff_ff80);
        put(enc_i(rv32i_pkg::op_load, 3'b101, 26, 1, 0), 26, 32'h0000_7f82);
        // stores into word 0x14, then read back merged
        put({20'hdeadc, 5'd2, 7'b0110111}, 2, 32'hdead_c000);
        put(enc_i(rv32i_pkg::op_imm, 3'b000, 2, 2, -32'h111), 2, 32'hdead_beef);
        put_store(enc_s(3'b010, 2, 1, 4), 4'b1111, 32'hdead_beef);
        put_store(enc_s(3'b000, 3, 1, 5), 4'b0010, 32'h0000_0300);
        put_store(enc_s(3'b001, 20, 1, 6), 4'b1100, 32'h0008_0000);
        put(enc_i(rv32i_pkg::op_load, 3'b010, 27, 1, 4), 27, 32'h0008_03ef);
        put_store(enc_s(3'b000, 12, 1, 7), 4'b1000, 32'h0700_0000);
        put(enc_i(rv32i_pkg::op_load, 3'b001, 28, 1, 6), 28, 32'h0000_0708);
        // each branch taken, skipping one, then not taken
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3) begin
                continue;
            end
            put(enc_b(3'(f), (f == 4 || f == 7) ? 5'd2 : 5'd3,
                (f == 4 || f == 7) ? 5'd3 : (f == 0 ? 5'd3 : 5'd2), 8), 0, 32'h0);
            skip(poison);
            put(enc_b(3'(f), (f == 4 || f == 7) ? 5'd3 : (f == 1 ? 5'd3 : 5'd2),
                (f == 4 || f == 7) ? 5'd2 : 5'd3, 8), 0, 32'h0);
        end
        // jumps, jalr target has its low bit cleared
        put(enc_j(5, 8), 5, `CPU_RESET_PC + 32'(n_imem * 4 + 4));
        skip(poison);
        put({20'h0, 5'd6, 7'b0010111}, 6, `CPU_RESET_PC + 32'(n_imem * 4));
        put(enc_i(rv32i_pkg::op_jalr, 3'b000, 7, 6, 13), 7, `CPU_RESET_PC + 32'(n_imem * 4 + 4));
        skip(poison);
        put(enc_i(rv32i_pkg::op_imm, 3'b000, 8, 7, 1), 8, `CPU_RESET_PC + 32'(n_imem * 4 - 3));
    endtask

    // instruction cache, 0 to 3 idle cycles
    always @(posedge clk) begin
        i_resp <= 1'b0;
        if (rst_n && i_read && !i_resp) begin
            if (!i_busy) begin
                i_busy = 1'b1;
                i_cnt  = int'($urandom % 4);
            end
            if (i_cnt == 0) begin
                i_resp  <= 1'b1;
                i_rdata <= (i_addr[31:2] < 128) ? imem[i_addr[8:2]] : 32'h0000_0013;
                i_busy = 1'b0;
            end else begin
                i_cnt--;
            end
        end
    end

    // data cache, merges stores by byte enable
    always @(posedge clk) begin
        d_resp <= 1'b0;
        if (rst_n && (d_read || d_write) && !d_resp) begin
            if (!d_busy) begin
                d_busy = 1'b1;
                d_cnt  = int'($urandom % 4);
            end
            if (d_cnt == 0) begin
                d_resp <= 1'b1;
                d_busy = 1'b0;
                // the cache port only takes word addresses
                assert (d_addr[1:0] == 2'b00) else stop_with_error($sformatf(
                    "ERR d_addr low bits got %h expected %h", d_addr[1:0], 2'b00));
                if (d_read) begin
                    d_rdata <= dmem[d_addr[7:2]];
                end else begin
                    assert (st_be.size() != 0)
                        else stop_with_error("store seen with no store expected");
                    assert (d_byte_enable == st_be[0]) else stop_with_error($sformatf(
                        "ERR d_byte_enable got %h expected %h", d_byte_enable, st_be[0]));
                    assert (d_wdata == st_wd[0]) else stop_with_error($sformatf(
                        "ERR d_wdata got %h expected %h", d_wdata, st_wd[0]));
                    void'(st_be.pop_front());
                    void'(st_wd.pop_front());
                    for (int b = 0; b < 4; b++) begin
                        if (d_byte_enable[b]) begin
                            dmem[d_addr[7:2]][8*b +: 8] = d_wdata[8*b +: 8];
                        end
                    end
                end
            end else begin
                d_cnt--;
            end
        end
    end

    // limit scales with the retire table
    always @(posedge clk) begin
        cycles++;
        if (cycles > exp_pc.size() * 12 + 50) begin
            stop_with_error("timeout, program did not retire in time");
        end
    end

    initial begin
        void'($urandom(32'h8432e895));
        rst_n   = 1'b0;
        i_rdata = '0;
        i_resp  = 1'b0;
        d_rdata = '0;
        d_resp  = 1'b0;
        cycles  = 0;
        i_busy  = 1'b0;
        d_busy  = 1'b0;
        n_imem  = 0;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = {8'(i) ^ 8'h5a, ~8'(i), 8'(i) + 8'h33, 8'(i)};
        end
        dmem[4] = 32'h80f1_7f82;
        build_program();

        // request and retire lines quiet during reset
        repeat (4) begin
            @(negedge clk);
            assert (!i_read && !d_read && !d_write && !retire_valid)
                else stop_with_error("request or retire line high during reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;

        for (int k = 0; k < exp_pc.size(); k++) begin
            do begin
                @(negedge clk);
            end while (!retire_valid);
            assert (retire_pc == exp_pc[k]) else stop_with_error($sformatf(
                "ERR retire_pc got %h expected %h", retire_pc, exp_pc[k]));
            assert (retire_rd == exp_rd[k]) else stop_with_error($sformatf(
                "ERR retire_rd got %h expected %h", retire_rd, exp_rd[k]));
            assert (retire_wdata == exp_val[k]) else stop_with_error($sformatf(
                "ERR retire_wdata got %h expected %h", retire_wdata, exp_val[k]));
        end

        if (st_be.size() != 0) begin
            stop_with_error("some expected stores never reached the data cache");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule : cpu_tb
